/* design/core_cfg_pkg.sv */
// Core configuration for the branch resolution slice
// Widths, reset pc, predictor sizing and exception cause positions

package core_cfg_pkg;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Register and pc width
  localparam int XLEN = 32;

  // Fetch restarts here after reset
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // Sequential step, no compressed instructions
  localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

  ////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////

  localparam int EXC_W = 16;

  // Target not on a 4 byte boundary
  localparam int CAUSE_MISALIGNED_INSTR = 0;

  ////////////////////////////////////////
  // Branch prediction
  ////////////////////////////////////////

  // Global history length
  localparam int BP_HIST_BITS = 2;

  // Table index width and the lowest pc bit it uses
  localparam int PHT_IDX_BITS = 6;
  localparam int PHT_IDX_LSB  = 2;
  localparam int PHT_ENTRIES  = 1 << PHT_IDX_BITS;

endpackage

/* design/rv_isa_pkg.sv */
// RV32I encodings needed for control transfer resolution
// Opcodes, branch funct3 values, FENCE.I and the B/J instruction views

package rv_isa_pkg;

  ////////////////////////////////////////
  // Major opcodes, instruction bits 6:2
  ////////////////////////////////////////

  localparam logic [4:0] OPC_BRANCH  = 5'b11000;
  localparam logic [4:0] OPC_JAL     = 5'b11011;
  localparam logic [4:0] OPC_JALR    = 5'b11001;
  // FENCE and FENCE.I live here
  localparam logic [4:0] OPC_MISCMEM = 5'b00011;

  ////////////////////////////////////////
  // Branch conditions
  ////////////////////////////////////////

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  // 010 and 011 are reserved
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Full FENCE.I word, all other fields zero
  localparam logic [31:0] INSTR_FENCE_I = 32'h0000_100f;

  ////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////

  // Same 32 bits read as B-type or as J-type
  typedef union packed {
    // Conditional branch
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_fmt;
    // Jump and link
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_u;

endpackage

/* design/bp_pht.sv */
// Branch pattern history table
// 2-bit saturating counters, looked up at issue, trained by the branch unit

module bp_pht (
  input  logic                                   clk,
  input  logic                                   rstn,
  // Lookup side
  input  logic [core_cfg_pkg::XLEN-1:0]          lookup_pc,
  input  logic [core_cfg_pkg::BP_HIST_BITS-1:0]  history,
  output logic [1:0]                             pred,
  // Training side
  input  logic                                   upd,
  input  logic                                   upd_taken,
  input  logic [core_cfg_pkg::XLEN-1:0]          upd_pc,
  input  logic [core_cfg_pkg::BP_HIST_BITS-1:0]  upd_history
);

  ////////////////////////////////////////
  // Index hashing
  ////////////////////////////////////////

  // Gshare style, pc slice xor zero-extended history
  function automatic logic [core_cfg_pkg::PHT_IDX_BITS-1:0] pht_idx(
    input logic [core_cfg_pkg::XLEN-1:0]         pc,
    input logic [core_cfg_pkg::BP_HIST_BITS-1:0] hist
  );
    logic [core_cfg_pkg::PHT_IDX_BITS-1:0] pc_bits;
    logic [core_cfg_pkg::PHT_IDX_BITS-1:0] hist_ext;
    pc_bits  = pc[core_cfg_pkg::PHT_IDX_LSB +: core_cfg_pkg::PHT_IDX_BITS];
    hist_ext = {{(core_cfg_pkg::PHT_IDX_BITS - core_cfg_pkg::BP_HIST_BITS){1'b0}}, hist};
    return pc_bits ^ hist_ext;
  endfunction

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  logic [1:0]                            cnt [core_cfg_pkg::PHT_ENTRIES];
  logic [core_cfg_pkg::PHT_IDX_BITS-1:0] rd_idx;
  logic [core_cfg_pkg::PHT_IDX_BITS-1:0] wr_idx;
  logic [1:0]                            wr_cnt;
  logic [1:0]                            nxt_cnt;

  assign rd_idx = pht_idx(lookup_pc, history);
  assign wr_idx = pht_idx(upd_pc, upd_history);

  // Combinational read, bit 1 is the direction
  assign pred = cnt[rd_idx];

  ////////////////////////////////////////
  // Training
  ////////////////////////////////////////

  assign wr_cnt = cnt[wr_idx];

  // Saturate at 00 and 11
  always_comb begin
    nxt_cnt = wr_cnt;
    if (upd_taken) begin
      if (wr_cnt != 2'b11) begin
        nxt_cnt = wr_cnt + 2'b01;
      end
    end else begin
      if (wr_cnt != 2'b00) begin
        nxt_cnt = wr_cnt - 2'b01;
      end
    end
  end

  // All entries start weakly not taken
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < core_cfg_pkg::PHT_ENTRIES; i++) begin
        cnt[i] <= 2'b01;
      end
    end else if (upd) begin
      cnt[wr_idx] <= nxt_cnt;
    end
  end

endmodule

/* design/id_issue_reg.sv */
// Issue stage register in front of the branch unit
// Holds on stall, squashes to a bubble on either flush

module id_issue_reg (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             ex_stall,
  input  logic                             flush_in,
  input  logic                             st_flush,
  // From the issue port
  input  logic [core_cfg_pkg::XLEN-1:0]    in_pc,
  input  logic [core_cfg_pkg::XLEN-1:0]    in_instr,
  input  logic [core_cfg_pkg::XLEN-1:0]    in_opa,
  input  logic [core_cfg_pkg::XLEN-1:0]    in_opb,
  input  logic [core_cfg_pkg::EXC_W-1:0]   in_exception,
  input  logic                             in_bubble,
  input  logic [1:0]                       in_pred,
  // To the branch unit
  output logic [core_cfg_pkg::XLEN-1:0]    id_pc,
  output logic [core_cfg_pkg::XLEN-1:0]    id_instr,
  output logic [core_cfg_pkg::XLEN-1:0]    id_opa,
  output logic [core_cfg_pkg::XLEN-1:0]    id_opb,
  output logic [core_cfg_pkg::EXC_W-1:0]   id_exception,
  output logic                             id_bubble,
  output logic [1:0]                       id_pred
);

  logic squash;
  logic bubble_q;

  // Any flush kills both the held and the arriving instruction
  assign squash = flush_in | st_flush;

  // Held entry looks like a bubble as soon as a flush shows up
  assign id_bubble = bubble_q | squash;

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bubble_q     <= 1'b1;
      id_pc        <= '0;
      id_instr     <= '0;
      id_opa       <= '0;
      id_opb       <= '0;
      id_exception <= '0;
      id_pred      <= 2'b00;
    end else begin
      // Flush wins over stall
      if (squash) begin
        bubble_q <= 1'b1;
      end else if (!ex_stall) begin
        bubble_q <= in_bubble;
      end
      if (!ex_stall) begin
        id_pc        <= in_pc;
        id_instr     <= in_instr;
        id_opa       <= in_opa;
        id_opb       <= in_opb;
        id_exception <= in_exception;
        id_pred      <= in_pred;
      end
    end
  end

endmodule

/* design/branch_unit.sv */
// Branch resolution for JAL, JALR, conditional branches and FENCE.I
// Produces next pc, pipeline and cache flushes, predictor training and history

module branch_unit (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  logic                                   ex_stall,
  input  logic                                   st_flush,
  // Issued instruction
  input  logic [core_cfg_pkg::XLEN-1:0]          id_pc,
  input  logic [core_cfg_pkg::XLEN-1:0]          id_instr,
  input  logic [core_cfg_pkg::XLEN-1:0]          id_opa,
  input  logic [core_cfg_pkg::XLEN-1:0]          id_opb,
  input  logic [core_cfg_pkg::EXC_W-1:0]         id_exception,
  input  logic                                   id_bubble,
  input  logic [1:0]                             id_pred,
  // Resolution results
  output logic [core_cfg_pkg::XLEN-1:0]          next_pc,
  output logic                                   bu_flush,
  output logic                                   cache_flush,
  output logic [core_cfg_pkg::EXC_W-1:0]         exception,
  // Predictor side
  output logic [core_cfg_pkg::BP_HIST_BITS-1:0]  bp_history,
  output logic                                   bp_update,
  output logic                                   bp_btaken,
  output logic [core_cfg_pkg::XLEN-1:0]          bp_pc,
  output logic [core_cfg_pkg::BP_HIST_BITS-1:0]  bp_upd_history
);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  rv_isa_pkg::instr_u                    instr;
  logic [4:0]                            opc;
  logic [core_cfg_pkg::XLEN-1:0]         imm_b;
  logic [core_cfg_pkg::XLEN-1:0]         imm_j;
  logic [core_cfg_pkg::XLEN-1:0]         pc_seq;
  logic [core_cfg_pkg::XLEN-1:0]         jalr_sum;

  // Resolved this cycle
  logic                                  btaken;
  logic                                  upd;
  logic                                  pipeflush;
  logic                                  cflush;
  logic                                  chk_align;
  logic [core_cfg_pkg::XLEN-1:0]         nxt_pc;

  // One extra bit, newest outcome sits in bit 0
  logic [core_cfg_pkg::BP_HIST_BITS:0]   hist_q;

  assign instr = id_instr;
  assign opc   = instr.b_fmt.opcode[6:2];

  // B-type offset, 13 bits sign-extended
  assign imm_b = {{(core_cfg_pkg::XLEN-13){instr.b_fmt.imm12}},
                  instr.b_fmt.imm12, instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};

  // J-type offset, 21 bits sign-extended
  assign imm_j = {{(core_cfg_pkg::XLEN-21){instr.j_fmt.imm20}},
                  instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                  instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

  assign pc_seq   = id_pc + core_cfg_pkg::INSTR_BYTES;
  assign jalr_sum = id_opa + id_opb;

  ////////////////////////////////////////
  // Resolution
  ////////////////////////////////////////

  always_comb begin
    // Defaults cover bubbles and non-control instructions
    btaken    = 1'b0;
    upd       = 1'b0;
    pipeflush = 1'b0;
    cflush    = 1'b0;
    chk_align = 1'b0;
    nxt_pc    = pc_seq;
    if (!id_bubble) begin
      case (opc)
        rv_isa_pkg::OPC_JAL: begin
          // Fetch already redirected, nothing to flush
          btaken = 1'b1;
          nxt_pc = id_pc + imm_j;
        end
        rv_isa_pkg::OPC_JALR: begin
          btaken    = 1'b1;
          pipeflush = 1'b1;
          chk_align = 1'b1;
          nxt_pc    = {jalr_sum[core_cfg_pkg::XLEN-1:1], 1'b0};
        end
        rv_isa_pkg::OPC_BRANCH: begin
          upd       = 1'b1;
          chk_align = 1'b1;
          case (instr.b_fmt.funct3)
            rv_isa_pkg::F3_BEQ:  btaken = (id_opa == id_opb);
            rv_isa_pkg::F3_BNE:  btaken = (id_opa != id_opb);
            rv_isa_pkg::F3_BLT:  btaken = ($signed(id_opa) < $signed(id_opb));
            rv_isa_pkg::F3_BGE:  btaken = ($signed(id_opa) >= $signed(id_opb));
            rv_isa_pkg::F3_BLTU: btaken = (id_opa < id_opb);
            rv_isa_pkg::F3_BGEU: btaken = (id_opa >= id_opb);
            default: begin
              // Reserved funct3, falls through as sequential
              upd       = 1'b0;
              chk_align = 1'b0;
            end
          endcase
          if (upd) begin
            // Mispredict against counter MSB
            pipeflush = btaken ^ id_pred[1];
            nxt_pc    = btaken ? id_pc + imm_b : pc_seq;
          end
        end
        rv_isa_pkg::OPC_MISCMEM: begin
          if (id_instr == rv_isa_pkg::INSTR_FENCE_I) begin
            pipeflush = 1'b1;
            cflush    = 1'b1;
          end
        end
        default: begin
          nxt_pc = pc_seq;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  // Pulses drop to zero on stall, everything else holds
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      next_pc     <= core_cfg_pkg::PC_INIT;
      bu_flush    <= 1'b1;
      cache_flush <= 1'b0;
      bp_update   <= 1'b0;
      bp_btaken   <= 1'b0;
      exception   <= '0;
      hist_q      <= '0;
    end else if (ex_stall) begin
      bu_flush    <= 1'b0;
      cache_flush <= 1'b0;
      bp_update   <= 1'b0;
    end else begin
      next_pc     <= nxt_pc;
      bu_flush    <= pipeflush;
      cache_flush <= cflush;
      bp_update   <= upd;
      bp_btaken   <= btaken;
      if (bu_flush || st_flush) begin
        exception <= '0;
      end else begin
        exception <= id_exception;
        exception[core_cfg_pkg::CAUSE_MISALIGNED_INSTR] <=
          id_exception[core_cfg_pkg::CAUSE_MISALIGNED_INSTR] | (chk_align & |nxt_pc[1:0]);
      end
      if (upd) begin
        hist_q <= {hist_q[core_cfg_pkg::BP_HIST_BITS-1:0], btaken};
      end
    end
  end

  // Training address and history, only meaningful with bp_update
  always_ff @(posedge clk) begin
    if (!ex_stall && upd) begin
      bp_pc          <= id_pc;
      bp_upd_history <= bp_history;
    end
  end

  // Current outcome left out of the lookup history
  assign bp_history = hist_q[core_cfg_pkg::BP_HIST_BITS:1];

endmodule

/* design/branch_subsys.sv */
// Branch resolution subsystem top
// Pattern history table, issue register and branch unit

module branch_subsys (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            ex_stall,
  input  logic                            st_flush,
  // Issue port
  input  logic [core_cfg_pkg::XLEN-1:0]   in_pc,
  input  logic [core_cfg_pkg::XLEN-1:0]   in_instr,
  input  logic [core_cfg_pkg::XLEN-1:0]   in_opa,
  input  logic [core_cfg_pkg::XLEN-1:0]   in_opb,
  input  logic [core_cfg_pkg::EXC_W-1:0]  in_exception,
  input  logic                            in_bubble,
  // Results
  output logic [core_cfg_pkg::XLEN-1:0]   next_pc,
  output logic                            bu_flush,
  output logic                            cache_flush,
  output logic [core_cfg_pkg::EXC_W-1:0]  exception,
  output logic                            bp_update,
  output logic                            bp_btaken
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  logic [1:0]                             pred;
  logic [core_cfg_pkg::BP_HIST_BITS-1:0]  bp_history;
  logic [core_cfg_pkg::BP_HIST_BITS-1:0]  bp_upd_history;
  logic [core_cfg_pkg::XLEN-1:0]          bp_pc;
  logic [core_cfg_pkg::XLEN-1:0]          id_pc;
  logic [core_cfg_pkg::XLEN-1:0]          id_instr;
  logic [core_cfg_pkg::XLEN-1:0]          id_opa;
  logic [core_cfg_pkg::XLEN-1:0]          id_opb;
  logic [core_cfg_pkg::EXC_W-1:0]         id_exception;
  logic                                   id_bubble;
  logic [1:0]                             id_pred;

  // Lookup at issue, training two edges later
  bp_pht bp_pht_i (
    .clk         (clk),
    .rstn        (rstn),
    .lookup_pc   (in_pc),
    .history     (bp_history),
    .pred        (pred),
    .upd         (bp_update),
    .upd_taken   (bp_btaken),
    .upd_pc      (bp_pc),
    .upd_history (bp_upd_history)
  );

  id_issue_reg id_issue_reg_i (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .flush_in     (bu_flush),
    .st_flush     (st_flush),
    .in_pc        (in_pc),
    .in_instr     (in_instr),
    .in_opa       (in_opa),
    .in_opb       (in_opb),
    .in_exception (in_exception),
    .in_bubble    (in_bubble),
    .in_pred      (pred),
    .id_pc        (id_pc),
    .id_instr     (id_instr),
    .id_opa       (id_opa),
    .id_opb       (id_opb),
    .id_exception (id_exception),
    .id_bubble    (id_bubble),
    .id_pred      (id_pred)
  );

  branch_unit branch_unit_i (
    .clk            (clk),
    .rstn           (rstn),
    .ex_stall       (ex_stall),
    .st_flush       (st_flush),
    .id_pc          (id_pc),
    .id_instr       (id_instr),
    .id_opa         (id_opa),
    .id_opb         (id_opb),
    .id_exception   (id_exception),
    .id_bubble      (id_bubble),
    .id_pred        (id_pred),
    .next_pc        (next_pc),
    .bu_flush       (bu_flush),
    .cache_flush    (cache_flush),
    .exception      (exception),
    .bp_history     (bp_history),
    .bp_update      (bp_update),
    .bp_btaken      (bp_btaken),
    .bp_pc          (bp_pc),
    .bp_upd_history (bp_upd_history)
  );

endmodule

/* verif/branch_model.svh */
// Cycle model of the branch slice for the testbench
// Table, history, issue register squash and resolution, stepped once per edge

`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

// Predictor state
logic [1:0]                            ref_pht [core_cfg_pkg::PHT_ENTRIES];
logic [core_cfg_pkg::BP_HIST_BITS:0]   ref_hist;
logic [core_cfg_pkg::XLEN-1:0]         ref_upd_pc;
logic [core_cfg_pkg::BP_HIST_BITS-1:0] ref_upd_hist;

// Issue register contents
logic                                  iss_bubble;
logic [core_cfg_pkg::XLEN-1:0]         iss_pc;
logic [core_cfg_pkg::XLEN-1:0]         iss_instr;
logic [core_cfg_pkg::XLEN-1:0]         iss_opa;
logic [core_cfg_pkg::XLEN-1:0]         iss_opb;
logic [core_cfg_pkg::EXC_W-1:0]        iss_exc;
logic [1:0]                            iss_pred;

// Expected registered outputs
logic [core_cfg_pkg::XLEN-1:0]         exp_next_pc;
logic                                  exp_bu_flush;
logic                                  exp_cache_flush;
logic                                  exp_bp_update;
logic                                  exp_bp_btaken;
logic [core_cfg_pkg::EXC_W-1:0]        exp_exc;

// pc word bits xor history, history zero-extended
function automatic logic [core_cfg_pkg::PHT_IDX_BITS-1:0] table_index(
  input logic [core_cfg_pkg::XLEN-1:0]         pc,
  input logic [core_cfg_pkg::BP_HIST_BITS-1:0] hist
);
  logic [core_cfg_pkg::PHT_IDX_BITS-1:0] hist_wide;
  hist_wide = '0;
  hist_wide[core_cfg_pkg::BP_HIST_BITS-1:0] = hist;
  return pc[core_cfg_pkg::PHT_IDX_LSB +: core_cfg_pkg::PHT_IDX_BITS] ^ hist_wide;
endfunction

function automatic logic [1:0] counter_next(input logic [1:0] cnt, input logic taken);
  if (taken) begin
    return (cnt == 2'b11) ? cnt : cnt + 2'b01;
  end
  return (cnt == 2'b00) ? cnt : cnt - 2'b01;
endfunction

// Signed compare from the sign bits, unsigned otherwise
function automatic logic cond_taken(
  input logic [2:0]                    f3,
  input logic [core_cfg_pkg::XLEN-1:0] a,
  input logic [core_cfg_pkg::XLEN-1:0] b
);
  logic lt_u;
  logic lt_s;
  lt_u = (a < b);
  lt_s = (a[core_cfg_pkg::XLEN-1] != b[core_cfg_pkg::XLEN-1]) ? a[core_cfg_pkg::XLEN-1] : lt_u;
  case (f3)
    rv_isa_pkg::F3_BEQ:  return a == b;
    rv_isa_pkg::F3_BNE:  return a != b;
    rv_isa_pkg::F3_BLT:  return lt_s;
    rv_isa_pkg::F3_BGE:  return !lt_s;
    rv_isa_pkg::F3_BLTU: return lt_u;
    default:             return !lt_u;
  endcase
endfunction

task automatic model_reset();
  int i;
  for (i = 0; i < core_cfg_pkg::PHT_ENTRIES; i++) begin
    ref_pht[i] = 2'b01;
  end
  ref_hist        = '0;
  ref_upd_pc      = '0;
  ref_upd_hist    = '0;
  iss_bubble      = 1'b1;
  iss_pc          = '0;
  iss_instr       = '0;
  iss_opa         = '0;
  iss_opb         = '0;
  iss_exc         = '0;
  iss_pred        = 2'b00;
  exp_next_pc     = core_cfg_pkg::PC_INIT;
  exp_bu_flush    = 1'b1;
  exp_cache_flush = 1'b0;
  exp_bp_update   = 1'b0;
  exp_bp_btaken   = 1'b0;
  exp_exc         = '0;
endtask

// One rising edge, inputs are the values driven before it
task automatic model_step();
  logic [1:0]                            pred_now;
  logic                                  squash;
  logic                                  bub;
  logic [4:0]                            opc;
  logic [2:0]                            f3;
  logic                                  taken;
  logic                                  upd;
  logic                                  pflush;
  logic                                  cflush;
  logic                                  align;
  logic [core_cfg_pkg::XLEN-1:0]         nxt;
  logic [core_cfg_pkg::XLEN-1:0]         sum;
  logic [core_cfg_pkg::XLEN-1:0]         imm_b;
  logic [core_cfg_pkg::XLEN-1:0]         imm_j;
  logic [core_cfg_pkg::PHT_IDX_BITS-1:0] widx;
  pred_now = ref_pht[table_index(in_pc, ref_hist[core_cfg_pkg::BP_HIST_BITS:1])];
  squash   = exp_bu_flush | st_flush;
  bub      = iss_bubble | squash;
  opc      = iss_instr[6:2];
  f3       = iss_instr[14:12];
  // Immediates straight from the RV32I bit layout
  imm_b = {{19{iss_instr[31]}}, iss_instr[31], iss_instr[7], iss_instr[30:25],
           iss_instr[11:8], 1'b0};
  imm_j = {{11{iss_instr[31]}}, iss_instr[31], iss_instr[19:12], iss_instr[20],
           iss_instr[30:21], 1'b0};
  sum    = iss_opa + iss_opb;
  nxt    = iss_pc + 32'd4;
  taken  = 1'b0;
  upd    = 1'b0;
  pflush = 1'b0;
  cflush = 1'b0;
  align  = 1'b0;
  if (!bub) begin
    if (opc == rv_isa_pkg::OPC_JAL) begin
      taken = 1'b1;
      nxt   = iss_pc + imm_j;
    end else if (opc == rv_isa_pkg::OPC_JALR) begin
      taken  = 1'b1;
      pflush = 1'b1;
      align  = 1'b1;
      nxt    = {sum[core_cfg_pkg::XLEN-1:1], 1'b0};
    end else if (opc == rv_isa_pkg::OPC_BRANCH && f3[2:1] != 2'b01) begin
      // 010 and 011 are not branches
      upd    = 1'b1;
      align  = 1'b1;
      taken  = cond_taken(f3, iss_opa, iss_opb);
      pflush = taken ^ iss_pred[1];
      if (taken) begin
        nxt = iss_pc + imm_b;
      end
    end else if (iss_instr == rv_isa_pkg::INSTR_FENCE_I) begin
      pflush = 1'b1;
      cflush = 1'b1;
    end
  end
  // Training from last edge's update
  if (exp_bp_update) begin
    widx          = table_index(ref_upd_pc, ref_upd_hist);
    ref_pht[widx] = counter_next(ref_pht[widx], exp_bp_btaken);
  end
  if (!ex_stall && upd) begin
    ref_upd_pc   = iss_pc;
    ref_upd_hist = ref_hist[core_cfg_pkg::BP_HIST_BITS:1];
  end
  if (ex_stall) begin
    exp_bu_flush    = 1'b0;
    exp_cache_flush = 1'b0;
    exp_bp_update   = 1'b0;
  end else begin
    exp_next_pc     = nxt;
    exp_bu_flush    = pflush;
    exp_cache_flush = cflush;
    exp_bp_update   = upd;
    exp_bp_btaken   = taken;
    if (squash) begin
      exp_exc = '0;
    end else begin
      exp_exc = iss_exc;
      exp_exc[core_cfg_pkg::CAUSE_MISALIGNED_INSTR] =
        iss_exc[core_cfg_pkg::CAUSE_MISALIGNED_INSTR] | (align & (nxt[1:0] != 2'b00));
    end
    if (upd) begin
      ref_hist = {ref_hist[core_cfg_pkg::BP_HIST_BITS-1:0], taken};
    end
  end
  // Issue register, squash beats stall
  if (squash) begin
    iss_bubble = 1'b1;
  end else if (!ex_stall) begin
    iss_bubble = in_bubble;
  end
  if (!ex_stall) begin
    iss_pc    = in_pc;
    iss_instr = in_instr;
    iss_opa   = in_opa;
    iss_opb   = in_opb;
    iss_exc   = in_exception;
    iss_pred  = pred_now;
  end
endtask

`endif

/* verif/branch_subsys_tb.sv */
// Testbench for the branch resolution subsystem
// Seeded random issue stream, checked every cycle against a cycle model

module branch_subsys_tb;

  localparam int CLK_HALF      = 5;
  localparam int DRIVE_DELAY   = 1;
  localparam int NUM_CYCLES    = 3000;
  localparam int RESET_TIMEOUT = 8;
  localparam int DRAIN_TIMEOUT = 16;

  logic                                  clk;
  logic                                  rstn;
  logic                                  ex_stall;
  logic                                  st_flush;
  logic [core_cfg_pkg::XLEN-1:0]         in_pc;
  logic [core_cfg_pkg::XLEN-1:0]         in_instr;
  logic [core_cfg_pkg::XLEN-1:0]         in_opa;
  logic [core_cfg_pkg::XLEN-1:0]         in_opb;
  logic [core_cfg_pkg::EXC_W-1:0]        in_exception;
  logic                                  in_bubble;
  logic [core_cfg_pkg::XLEN-1:0]         next_pc;
  logic                                  bu_flush;
  logic                                  cache_flush;
  logic [core_cfg_pkg::EXC_W-1:0]        exception;
  logic                                  bp_update;
  logic                                  bp_btaken;

  string test_name;
  int    cycle;
  int    stall_left;
  int    n_mispredict;
  int    n_fence;
  int    n_misalign;

  `include "branch_model.svh"

  branch_subsys branch_subsys_i (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .st_flush     (st_flush),
    .in_pc        (in_pc),
    .in_instr     (in_instr),
    .in_opa       (in_opa),
    .in_opb       (in_opb),
    .in_exception (in_exception),
    .in_bubble    (in_bubble),
    .next_pc      (next_pc),
    .bu_flush     (bu_flush),
    .cache_flush  (cache_flush),
    .exception    (exception),
    .bp_update    (bp_update),
    .bp_btaken    (bp_btaken)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pc(input string what, input logic [core_cfg_pkg::XLEN-1:0] exp,
                          input logic [core_cfg_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s cycle %0d: expected %h actual %h",
               test_name, what, cycle, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ctl(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s cycle %0d: expected %b actual %b",
               test_name, what, cycle, exp, act);
      abort_run();
    end
  endtask

  task automatic check_exc(input string what, input logic [core_cfg_pkg::EXC_W-1:0] exp,
                           input logic [core_cfg_pkg::EXC_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s cycle %0d: expected %h actual %h",
               test_name, what, cycle, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_outputs();
    check_pc("next_pc", exp_next_pc, next_pc);
    check_ctl("bu_flush", exp_bu_flush, bu_flush);
    check_ctl("cache_flush", exp_cache_flush, cache_flush);
    check_ctl("bp_update", exp_bp_update, bp_update);
    check_ctl("bp_btaken", exp_bp_btaken, bp_btaken);
    check_exc("exception", exp_exc, exception);
  endtask

  // Edge, model step, then compare once outputs settle
  task automatic tick();
    @(posedge clk);
    model_step();
    #DRIVE_DELAY;
    cycle++;
    compare_outputs();
    if (bu_flush && bp_update) begin
      n_mispredict++;
    end
    if (cache_flush) begin
      n_fence++;
    end
    if (exception[core_cfg_pkg::CAUSE_MISALIGNED_INSTR]) begin
      n_misalign++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_idle();
    ex_stall     = 1'b0;
    st_flush     = 1'b0;
    in_bubble    = 1'b1;
    in_instr     = '0;
    in_exception = '0;
  endtask

  task automatic drive_random();
    rv_isa_pkg::instr_u            iw;
    logic [core_cfg_pkg::XLEN-1:0] tmp;
    int                            kind;
    int                            opmode;
    kind   = $urandom_range(0, 15);
    opmode = $urandom_range(0, 3);
    iw     = $urandom;
    // Stall bursts of one to four cycles
    if (stall_left == 0 && $urandom_range(0, 7) == 0) begin
      stall_left = $urandom_range(1, 4);
    end
    ex_stall = (stall_left > 0);
    if (stall_left > 0) begin
      stall_left--;
    end
    st_flush  = ($urandom_range(0, 19) == 0);
    in_bubble = ($urandom_range(0, 9) == 0);
    // Small pc window so table entries get reused
    in_pc = core_cfg_pkg::PC_INIT + ($urandom_range(0, 255) << 2);
    if ($urandom_range(0, 15) == 0) begin
      in_pc = in_pc | $urandom_range(1, 3);
    end
    in_exception = '0;
    if ($urandom_range(0, 7) == 0) begin
      tmp          = $urandom;
      in_exception = tmp[core_cfg_pkg::EXC_W-1:0];
    end
    case (opmode)
      0: begin
        in_opa = $urandom;
        in_opb = $urandom;
      end
      1: begin
        in_opa = $urandom;
        in_opb = in_opa;
      end
      2: begin
        // One negative, one positive
        in_opa = 32'h8000_0000 | $urandom_range(0, 255);
        in_opb = $urandom_range(0, 255);
        if ($urandom_range(0, 1) == 1) begin
          tmp    = in_opa;
          in_opa = in_opb;
          in_opb = tmp;
        end
      end
      default: begin
        in_opa = $urandom_range(0, 3);
        in_opb = $urandom_range(0, 3);
      end
    endcase
    // Random funct3 includes the reserved codes
    if (kind <= 6) begin
      iw.b_fmt.opcode = {rv_isa_pkg::OPC_BRANCH, 2'b11};
    end else if (kind <= 8) begin
      iw.j_fmt.opcode = {rv_isa_pkg::OPC_JAL, 2'b11};
    end else if (kind <= 10) begin
      iw.b_fmt.opcode = {rv_isa_pkg::OPC_JALR, 2'b11};
      iw.b_fmt.funct3 = 3'b000;
    end else if (kind == 11) begin
      iw = rv_isa_pkg::INSTR_FENCE_I;
    end else if (kind == 12) begin
      // Plain FENCE, no flush expected
      iw.b_fmt.opcode = {rv_isa_pkg::OPC_MISCMEM, 2'b11};
      iw.b_fmt.funct3 = 3'b000;
    end
    in_instr = iw;
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    int waited;
    int quiet;
    void'($urandom(32'hd80c_661d));
    rstn         = 1'b0;
    in_pc        = core_cfg_pkg::PC_INIT;
    in_opa       = '0;
    in_opb       = '0;
    drive_idle();
    stall_left   = 0;
    cycle        = 0;
    n_mispredict = 0;
    n_fence      = 0;
    n_misalign   = 0;
    test_name    = "reset";
    model_reset();
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rstn = 1'b1;
    compare_outputs();
    // Issued under the reset flush, must be squashed
    drive_random();
    ex_stall   = 1'b0;
    stall_left = 0;
    waited     = 0;
    while (bu_flush !== 1'b0) begin
      if (waited >= RESET_TIMEOUT) begin
        $display("Timeout: bu_flush never dropped after reset release");
        abort_run();
      end
      tick();
      drive_idle();
      waited++;
    end
    test_name = "random";
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_random();
      tick();
    end
    // Let the last results come out
    test_name = "drain";
    drive_idle();
    waited = 0;
    quiet  = 0;
    while (quiet < 2) begin
      if (waited >= DRAIN_TIMEOUT) begin
        $display("Timeout: flush or update pulses kept coming after stimulus ended");
        abort_run();
      end
      tick();
      waited++;
      if (bu_flush || cache_flush || bp_update) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    $display("Mispredict flushes %0d, cache flushes %0d, misaligned targets %0d",
             n_mispredict, n_fence, n_misalign);
    // Random stream has to reach every flush and exception path
    if (n_mispredict == 0 || n_fence == 0 || n_misalign == 0) begin
      $display("Stimulus never hit a mispredict, a FENCE.I or a misaligned target");
      abort_run();
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

/* branch_subsys.f */
+incdir+verif
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/bp_pht.sv
design/id_issue_reg.sv
design/branch_unit.sv
design/branch_subsys.sv
verif/branch_subsys_tb.sv
